// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN 32
`define RESET_PC 32'h0000_0000

`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011
`define OPC_SYSTEM 7'b1110011

`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341

`define INST_NOP    32'h0000_0013
`define INST_EBREAK 32'h0010_0073

`endif

// File: design/rv_pkg.sv
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [4:0]       reg_idx_t;
	typedef logic [3:0]       strb_t;
	typedef logic [11:0]      csr_addr_t;
	typedef logic [6:0]       opcode_t;
	typedef logic [2:0]       funct3_t;
	typedef logic [6:0]       funct7_t;

	typedef enum logic [2:0] {
		TYPE_R = 3'd0,
		TYPE_I = 3'd1,
		TYPE_S = 3'd2,
		TYPE_B = 3'd3,
		TYPE_U = 3'd4,
		TYPE_J = 3'd5
	} inst_type_t;

	typedef enum logic [3:0] {
		ADD, SUB, AND, XOR, OR, SRL, SRA, SLL, LESS, ULESS
	} alu_op_t;

	typedef enum logic [1:0] {
		FETCH, EXEC, MEM, HALT
	} core_state_t;

	typedef struct packed {
		opcode_t    opcode;
		inst_type_t inst_type;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		word_t      imm;
		funct3_t    funct3;
		funct7_t    funct7;
		csr_addr_t  csr_addr;
		logic       is_load;
		logic       is_store;
		logic       is_csr;
		logic       is_ebreak;
		logic       wr_en;
	} decoded_t;

	typedef struct packed {
		word_t val;
		logic  jump_en;
		word_t jump;       // zero when not taken
		word_t mem_addr;
		word_t mem_wdata;  // already on its byte lane
		strb_t wmask;
		word_t csr_wdata;
	} exe_res_t;

endpackage

`default_nettype wire

// File: design/rv_idu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_idu
	import rv_pkg::*;
(
	input  wire word_t inst,
	output decoded_t   dec
);

	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec = '0;
		dec.opcode = inst[6:0];
		dec.rd = inst[11:7];
		dec.funct3 = inst[14:12];
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.funct7 = inst[31:25];
		dec.csr_addr = inst[31:20];
		dec.inst_type = TYPE_I;  // unknown opcodes fall through as no-ops
		case (inst[6:0])
			`OPC_LUI, `OPC_AUIPC: begin
				dec.inst_type = TYPE_U;
				dec.imm = imm_u;
				dec.wr_en = 1'b1;
			end
			`OPC_JAL: begin
				dec.inst_type = TYPE_J;
				dec.imm = imm_j;
				dec.wr_en = 1'b1;
			end
			`OPC_JALR, `OPC_OPIMM: begin
				dec.imm = imm_i;
				dec.wr_en = 1'b1;
			end
			`OPC_LOAD: begin
				dec.imm = imm_i;
				dec.is_load = 1'b1;  // always a full word
				dec.wr_en = 1'b1;
			end
			`OPC_STORE: begin
				dec.inst_type = TYPE_S;
				dec.imm = imm_s;
				dec.is_store = 1'b1;
			end
			`OPC_BRANCH: begin
				dec.inst_type = TYPE_B;
				dec.imm = imm_b;
			end
			`OPC_OP: begin
				dec.inst_type = TYPE_R;
				dec.wr_en = 1'b1;
			end
			`OPC_SYSTEM: begin
				dec.imm = imm_i;
				dec.is_csr = (inst[14:12] == 3'b001) || (inst[14:12] == 3'b010);
				dec.is_ebreak = (inst == `INST_EBREAK);
				dec.wr_en = dec.is_csr;  // rd gets the old csr value
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: design/rv_exu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_exu
	import rv_pkg::*;
(
	input  wire decoded_t dec,
	input  wire word_t    src1,
	input  wire word_t    src2,
	input  wire word_t    pc,
	input  wire word_t    csr_val,
	output exe_res_t      res
);

	word_t           loperand;
	word_t           roperand;
	alu_op_t         op;
	logic [`XLEN:0]  op_diff;
	logic            op_less;
	word_t           alu_val;
	logic [`XLEN:0]  br_diff;
	logic            less;
	logic            jump_cond;
	logic            jump_en;
	logic            is_jalr;
	word_t           jsum;
	word_t           mem_addr;
	strb_t           base_mask;
	word_t           csr_wdata;

	always_comb begin
		case (dec.opcode)
			`OPC_AUIPC, `OPC_JAL, `OPC_JALR: loperand = pc;
			`OPC_OPIMM, `OPC_OP: loperand = src1;
			default: loperand = '0;  // lui
		endcase
		case (dec.opcode)
			`OPC_LUI, `OPC_AUIPC, `OPC_OPIMM: roperand = dec.imm;
			`OPC_JAL, `OPC_JALR: roperand = `XLEN'd4;  // link value
			`OPC_OP: roperand = src2;
			default: roperand = '0;
		endcase
	end

	always_comb begin
		op = ADD;
		if (dec.inst_type == TYPE_R || dec.inst_type == TYPE_I) begin
			case (dec.funct3)
				3'b000: op = (dec.inst_type == TYPE_R && dec.funct7[5]) ? SUB : ADD;
				3'b001: op = SLL;
				3'b010: op = LESS;
				3'b011: op = ULESS;
				3'b100: op = XOR;
				3'b101: op = dec.funct7[5] ? SRA : SRL;
				3'b110: op = OR;
				3'b111: op = AND;
			endcase
		end
	end

	// borrow out doubles as unsigned less-than
	assign op_diff = {1'b0, loperand} - {1'b0, roperand};
	assign op_less = (loperand[`XLEN-1] & ~roperand[`XLEN-1])
		| (~(loperand[`XLEN-1] ^ roperand[`XLEN-1]) & op_diff[`XLEN-1]);

	always_comb begin
		case (op)
			ADD: alu_val = loperand + roperand;
			SUB: alu_val = op_diff[`XLEN-1:0];
			AND: alu_val = loperand & roperand;
			XOR: alu_val = loperand ^ roperand;
			OR: alu_val = loperand | roperand;
			SRL: alu_val = loperand >> roperand[4:0];
			SRA: alu_val = word_t'($signed(loperand) >>> roperand[4:0]);
			SLL: alu_val = loperand << roperand[4:0];
			LESS: alu_val = {{(`XLEN-1){1'b0}}, op_less};
			ULESS: alu_val = {{(`XLEN-1){1'b0}}, op_diff[`XLEN]};
			default: alu_val = '0;
		endcase
	end

	assign br_diff = {1'b0, src1} - {1'b0, src2};
	assign less = (src1[`XLEN-1] & ~src2[`XLEN-1])
		| (~(src1[`XLEN-1] ^ src2[`XLEN-1]) & br_diff[`XLEN-1]);

	always_comb begin
		case (dec.funct3)
			3'b000: jump_cond = ~|br_diff[`XLEN-1:0];  // beq
			3'b001: jump_cond = |br_diff[`XLEN-1:0];   // bne
			3'b100: jump_cond = less;
			3'b101: jump_cond = ~less;
			3'b110: jump_cond = br_diff[`XLEN];        // bltu
			3'b111: jump_cond = ~br_diff[`XLEN];       // bgeu
			default: jump_cond = 1'b0;
		endcase
	end

	assign is_jalr = (dec.opcode == `OPC_JALR);
	assign jump_en = (dec.inst_type == TYPE_J) || is_jalr
		|| ((dec.inst_type == TYPE_B) && jump_cond);
	assign jsum = (is_jalr ? src1 : pc) + dec.imm;

	assign mem_addr = src1 + dec.imm;
	always_comb begin
		case (dec.funct3[1:0])
			2'b00: base_mask = 4'h1;
			2'b01: base_mask = 4'h3;
			2'b10: base_mask = 4'hf;
			default: base_mask = 4'h0;
		endcase
		case (dec.funct3)
			3'b001: csr_wdata = src1;            // csrrw
			3'b010: csr_wdata = src1 | csr_val;  // csrrs
			default: csr_wdata = '0;
		endcase
	end

	always_comb begin
		res.val = alu_val;
		res.jump_en = jump_en;
		res.jump = {jsum[`XLEN-1:1], jsum[0] & ~is_jalr} & {`XLEN{jump_en}};
		res.mem_addr = mem_addr;
		res.mem_wdata = src2 << {mem_addr[1:0], 3'b000};
		res.wmask = strb_t'(base_mask << mem_addr[1:0]);
		res.csr_wdata = csr_wdata;
	end

	// decoder must never hand a store the jump type
	always_comb begin
		if (dec.is_store)
			assert (!jump_en) else $error("rv_exu: jump_en set on a store");
	end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
	import rv_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	input  wire reg_idx_t rs1,
	input  wire reg_idx_t rs2,
	input  wire reg_idx_t rd,
	input  wire           wr_en,
	input  wire word_t    wdata,
	output word_t         rdata1,
	output word_t         rdata2
);

	word_t regs [1:31];  // x0 has no storage

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: design/rv_csr.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_csr
	import rv_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire csr_addr_t addr,
	input  wire            wr_en,
	input  wire word_t     wdata,
	output word_t          rdata
);

	word_t mscratch;
	word_t mepc;

	always_comb begin
		case (addr)
			`CSR_MSCRATCH: rdata = mscratch;
			`CSR_MEPC: rdata = mepc;
			default: rdata = '0;  // unimplemented csr
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mscratch <= '0;
			mepc <= '0;
		end else if (wr_en) begin
			case (addr)
				`CSR_MSCRATCH: mscratch <= wdata;
				`CSR_MEPC: mepc <= wdata;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/rv_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module rv_apb_master
	import rv_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  wire        start,
	input  wire word_t addr,
	input  wire        write,
	input  wire word_t wdata,
	input  wire strb_t strb,
	output logic       done,
	output word_t      rdata,
	output word_t      paddr,
	output logic       psel,
	output logic       penable,
	output logic       pwrite,
	output word_t      pwdata,
	output strb_t      pstrb,
	input  wire word_t prdata,
	input  wire        pready,
	input  wire        pslverr
);

	typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_t;

	apb_state_t state;
	logic       accept;

	assign done = (state == ACCESS) && pready;
	assign accept = start && ((state == IDLE) || done);  // back to back on done
	assign rdata = prdata;
	assign psel = (state != IDLE);
	assign penable = (state == ACCESS);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			pwrite <= 1'b0;
			pstrb <= '0;
		end else begin
			case (state)
				IDLE: if (start) state <= SETUP;
				SETUP: state <= ACCESS;
				ACCESS: if (pready) state <= start ? SETUP : IDLE;
				default: state <= IDLE;
			endcase
			if (accept) begin
				pwrite <= write;
				pstrb <= strb;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			paddr <= addr;
			pwdata <= wdata;
		end
	end

	// a request is never dropped while a transfer is busy
	a_start_taken: assert property (@(posedge clk) disable iff (reset)
		start |-> ((state == IDLE) || done));
	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		(psel && !pready) |=> $stable(paddr));
	a_err_in_access: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> (psel && penable && pready));

endmodule

`default_nettype wire

// File: design/rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_core
	import rv_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	output word_t      paddr,
	output logic       psel,
	output logic       penable,
	output logic       pwrite,
	output word_t      pwdata,
	output strb_t      pstrb,
	input  wire word_t prdata,
	input  wire        pready,
	input  wire        pslverr,
	output logic       halted
);

	core_state_t state;
	word_t       pc;
	word_t       ir;
	logic        first;
	decoded_t    dec;
	exe_res_t    res;
	word_t       src1;
	word_t       src2;
	word_t       csr_val;
	word_t       pc_seq;
	word_t       pc_next;
	logic        req_start;
	word_t       req_addr;
	logic        req_write;
	strb_t       req_strb;
	logic        req_done;
	word_t       req_rdata;
	logic        rf_we;
	word_t       rf_wdata;
	logic        is_mem;

	rv_idu u_idu (.inst(ir), .dec(dec));
	rv_exu u_exu (.dec(dec), .src1(src1), .src2(src2), .pc(pc), .csr_val(csr_val), .res(res));
	rv_regfile u_regfile (.clk(clk), .reset(reset), .rs1(dec.rs1), .rs2(dec.rs2),
		.rd(dec.rd), .wr_en(rf_we), .wdata(rf_wdata), .rdata1(src1), .rdata2(src2));
	rv_csr u_csr (.clk(clk), .reset(reset), .addr(dec.csr_addr),
		.wr_en(state == EXEC && dec.is_csr), .wdata(res.csr_wdata), .rdata(csr_val));
	rv_apb_master u_apb (.clk(clk), .reset(reset), .start(req_start), .addr(req_addr),
		.write(req_write), .wdata(res.mem_wdata), .strb(req_strb), .done(req_done),
		.rdata(req_rdata), .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready), .pslverr(pslverr));

	assign is_mem = dec.is_load || dec.is_store;
	assign pc_seq = pc + `XLEN'd4;
	assign pc_next = res.jump_en ? res.jump : pc_seq;
	assign halted = (state == HALT);

	// next request goes out one cycle early so its setup phase overlaps the step
	always_comb begin
		req_start = 1'b0;
		req_addr = pc_next;
		req_write = 1'b0;
		req_strb = '0;
		case (state)
			FETCH: begin
				req_start = first;  // only the fetch right after reset
				req_addr = pc;
			end
			EXEC: begin
				req_start = !dec.is_ebreak;
				if (is_mem) begin
					req_addr = res.mem_addr;
					req_write = dec.is_store;
					req_strb = dec.is_store ? res.wmask : '0;
				end
			end
			MEM: begin
				req_start = req_done;
				req_addr = pc_seq;
			end
			default: ;
		endcase
	end

	always_comb begin
		rf_we = 1'b0;
		rf_wdata = dec.is_csr ? csr_val : res.val;
		if (state == EXEC && dec.wr_en && !dec.is_load) begin
			rf_we = 1'b1;
		end else if (state == MEM && dec.is_load && req_done) begin
			rf_we = 1'b1;
			rf_wdata = req_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH;
			pc <= `RESET_PC;
			ir <= `INST_NOP;
			first <= 1'b1;
		end else begin
			first <= 1'b0;
			case (state)
				FETCH: if (req_done) begin
					ir <= req_rdata;
					state <= EXEC;
				end
				EXEC: begin
					if (dec.is_ebreak) begin
						state <= HALT;
					end else if (is_mem) begin
						state <= MEM;
					end else begin
						pc <= pc_next;
						state <= FETCH;
					end
				end
				MEM: if (req_done) begin
					pc <= pc_seq;
					state <= FETCH;
				end
				default: ;  // halted for good
			endcase
		end
	end

	a_quiet_halt: assert property (@(posedge clk) disable iff (reset) halted |-> !psel);

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module tb_rv_core
	import rv_pkg::*;
();

	localparam int REF_ALU = 0;
	localparam int REF_BRANCH = 1;
	localparam int REF_CSR = 2;
	localparam int REF_STRB = 3;
	localparam int REF_LANE = 4;

	logic  clk;
	logic  reset;
	word_t paddr;
	logic  psel;
	logic  penable;
	logic  pwrite;
	word_t pwdata;
	strb_t pstrb;
	word_t prdata;
	logic  pready;
	logic  pslverr;
	logic  halted;

	word_t mem [256];
	int    wp;
	word_t prog_rng;
	word_t wait_rng;
	int    waits;
	int    errors;
	int    checks;
	logic  timed_out;
	word_t setup_addr;
	word_t exp_addr [$];
	word_t exp_data [$];
	strb_t exp_strb [$];
	string exp_name [$];
	string mon_name;

	rv_core UUT (.clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .halted(halted));

	always #4 clk = ~clk;

	function automatic word_t xorshift(input word_t s);
		word_t x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t rand_word();
		prog_rng = xorshift(prog_rng);
		return prog_rng;
	endfunction

	// expected results straight from the ISA rules
	function automatic word_t ref_result(input int kind, input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		word_t r;
		r = '0;
		case (kind)
			REF_ALU: case (f3)
				3'd0: r = alt ? a - b : a + b;
				3'd1: r = a << b[4:0];
				3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'd3: r = (a < b) ? 32'd1 : 32'd0;
				3'd4: r = a ^ b;
				3'd5: if (alt) r = $signed(a) >>> b[4:0]; else r = a >> b[4:0];
				3'd6: r = a | b;
				3'd7: r = a & b;
			endcase
			REF_BRANCH: case (f3)
				3'd0: r = (a == b) ? 32'd1 : 32'd0;
				3'd1: r = (a != b) ? 32'd1 : 32'd0;
				3'd4: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'd5: r = ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
				3'd6: r = (a < b) ? 32'd1 : 32'd0;
				3'd7: r = (a >= b) ? 32'd1 : 32'd0;
				default: r = '0;
			endcase
			REF_CSR: r = (f3 == 3'b001) ? b : (a | b);  // a old csr, b source
			REF_STRB: r = (f3 == 3'b000 ? 32'h1 : f3 == 3'b001 ? 32'h3 : 32'hf) << b[1:0];
			REF_LANE: r = a << (8 * b[1:0]);
			default: ;
		endcase
		return r;
	endfunction

	function automatic word_t byte_lanes(input strb_t s);
		return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
	endfunction

	function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, `OPC_OP};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic begin_program();
		for (int i = 0; i < 256; i++)
			mem[i] = 32'h0bad_0000 | i;
		wp = 0;
	endtask

	task automatic emit(input word_t w);
		mem[wp[7:0]] = w;
		wp++;
	endtask

	task automatic load_imm(input reg_idx_t rd, input word_t v);
		word_t hi;
		hi = v + 32'h800;  // addi sign-extends the low part
		emit(enc_u(hi[31:12], rd, `OPC_LUI));
		emit(enc_i(v[11:0], rd, 3'b000, rd, `OPC_OPIMM));
	endtask

	task automatic store_expect(input string name, input reg_idx_t rs2, input logic [2:0] f3,
		input logic [11:0] addr, input word_t val);
		strb_t s;
		s = strb_t'(ref_result(REF_STRB, f3, 1'b0, '0, {20'b0, addr}));
		emit(enc_s(addr, rs2, 5'd0, f3));
		exp_addr.push_back({20'b0, addr});
		exp_strb.push_back(s);
		exp_data.push_back(ref_result(REF_LANE, f3, 1'b0, val, {20'b0, addr}) & byte_lanes(s));
		exp_name.push_back(name);
	endtask

	task automatic csr_step(input string name, input logic [2:0] f3, input csr_addr_t addr,
		input reg_idx_t rs1, input word_t src, input reg_idx_t rd, input logic [11:0] off,
		inout word_t model);
		emit(enc_i(addr, rs1, f3, rd, `OPC_SYSTEM));
		store_expect(name, rd, 3'b010, off, model);  // rd gets the old value
		model = ref_result(REF_CSR, f3, 1'b0, model, src);
	endtask

	task automatic run_program(input string name);
		int n;
		reset = 1'b1;
		repeat (5) begin
			@(posedge clk);
			#1;
			assert (!psel && !halted) else begin
				errors++;
				$display("%s: psel or halted high during reset", name);
			end
		end
		reset = 1'b0;
		assert (!psel && !halted) else begin
			errors++;
			$display("%s: psel or halted high in the first cycle after reset", name);
		end
		n = 0;
		while (!psel && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!psel) begin
			errors++;
			timed_out = 1'b1;
			$display("%s: timeout waiting for the first fetch", name);
		end else begin
			check_word({name, " first paddr"}, `RESET_PC, paddr);
			check_word({name, " first pwrite"}, '0, {31'b0, pwrite});
			n = 0;
			while (!halted && n < 8000) begin
				@(posedge clk);
				#1;
				n++;
			end
			if (!halted) begin
				errors++;
				timed_out = 1'b1;
				$display("%s: timeout waiting for halted after ebreak", name);
			end else begin
				repeat (6) begin  // the monitor watches for stray transfers
					@(posedge clk);
					#1;
				end
				assert (exp_addr.size() == 0) else begin
					errors++;
					$display("%s: %0d expected stores never happened", name, exp_addr.size());
				end
			end
		end
		exp_addr.delete();
		exp_data.delete();
		exp_strb.delete();
		exp_name.delete();
	endtask

	task automatic test_alu();
		int r_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
		bit r_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
		int i_f3 [9] = '{0, 1, 2, 3, 4, 5, 5, 6, 7};
		bit i_alt [9] = '{0, 0, 0, 0, 0, 0, 1, 0, 0};
		word_t a;
		word_t b;
		word_t r;
		logic [11:0] imm;
		logic [11:0] off;
		begin_program();
		off = 12'h300;
		for (int round = 0; round < 2; round++) begin
			a = rand_word();
			b = rand_word();
			load_imm(5'd1, a);
			load_imm(5'd2, b);
			for (int k = 0; k < 10; k++) begin
				emit(enc_r(r_alt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(r_f3[k]), 5'd3));
				store_expect($sformatf("alu reg f3=%0d alt=%0d", r_f3[k], r_alt[k]), 5'd3,
					3'b010, off, ref_result(REF_ALU, 3'(r_f3[k]), r_alt[k], a, b));
				off += 12'd4;
			end
			for (int k = 0; k < 9; k++) begin
				r = rand_word();
				imm = (i_f3[k] == 1 || i_f3[k] == 5) ? {1'b0, i_alt[k], 5'b0, r[4:0]} : r[11:0];
				emit(enc_i(imm, 5'd1, 3'(i_f3[k]), 5'd4, `OPC_OPIMM));
				store_expect($sformatf("alu imm f3=%0d alt=%0d", i_f3[k], i_alt[k]), 5'd4,
					3'b010, off, ref_result(REF_ALU, 3'(i_f3[k]), i_alt[k], a,
					{{20{imm[11]}}, imm}));
				off += 12'd4;
			end
		end
		emit(`INST_EBREAK);
		run_program("alu");
	endtask

	task automatic test_branch();
		int b_f3 [6] = '{0, 1, 4, 5, 6, 7};
		word_t a;
		word_t b;
		word_t r;
		word_t link;
		logic [11:0] off;
		begin_program();
		off = 12'h300;
		load_imm(5'd5, 32'h600d_beef);  // marker
		for (int k = 0; k < 6; k++) begin
			a = rand_word();
			r = rand_word();
			b = r[0] ? a : rand_word();  // equal operands half the time
			load_imm(5'd1, a);
			load_imm(5'd2, b);
			emit(enc_b(13'd8, 5'd2, 5'd1, 3'(b_f3[k])));
			r = ref_result(REF_BRANCH, 3'(b_f3[k]), 1'b0, a, b);
			if (r[0])
				emit(enc_s(off, 5'd5, 5'd0, 3'b010));
			else
				store_expect($sformatf("branch f3=%0d fall-through", b_f3[k]), 5'd5, 3'b010,
					off, 32'h600d_beef);
			off += 12'd4;
		end
		link = word_t'(wp * 4) + 32'd4;
		emit(enc_j(21'd8, 5'd6));
		emit(enc_s(12'h3fc, 5'd0, 5'd0, 3'b010));  // must be skipped
		store_expect("jal link", 5'd6, 3'b010, off, link);
		off += 12'd4;
		link = word_t'((wp + 2) * 4) + 32'd4;
		load_imm(5'd7, link);  // link plus 5 is odd, bit 0 gets cleared
		emit(enc_i(12'd5, 5'd7, 3'b000, 5'd8, `OPC_JALR));
		emit(enc_s(12'h3fc, 5'd0, 5'd0, 3'b010));
		store_expect("jalr link", 5'd8, 3'b010, off, link);
		emit(`INST_EBREAK);
		run_program("branch");
	endtask

	task automatic test_partial();
		word_t d;
		begin_program();
		d = rand_word();
		load_imm(5'd9, d);
		for (int o = 0; o < 4; o++)
			store_expect($sformatf("sb offset %0d", o), 5'd9, 3'b000, 12'h380 + 12'(o), d);
		for (int o = 0; o < 3; o++)
			store_expect($sformatf("sh offset %0d", o), 5'd9, 3'b001, 12'h390 + 12'(o), d);
		store_expect("sw", 5'd9, 3'b010, 12'h3a0, d);
		emit(`INST_EBREAK);
		run_program("partial");
	endtask

	task automatic test_load_csr();
		word_t v;
		word_t w;
		word_t ms;
		word_t ep;
		begin_program();
		v = rand_word();
		w = rand_word();
		ms = '0;
		ep = '0;
		load_imm(5'd10, v);
		store_expect("sw before lw", 5'd10, 3'b010, 12'h3c0, v);
		emit(enc_i(12'h3c0, 5'd0, 3'b010, 5'd11, `OPC_LOAD));
		store_expect("lw readback", 5'd11, 3'b010, 12'h3c4, v);
		csr_step("csrrw mscratch first", 3'b001, `CSR_MSCRATCH, 5'd10, v, 5'd12, 12'h3c8, ms);
		load_imm(5'd13, w);
		csr_step("csrrw mscratch swap", 3'b001, `CSR_MSCRATCH, 5'd13, w, 5'd14, 12'h3cc, ms);
		csr_step("csrrs mscratch set", 3'b010, `CSR_MSCRATCH, 5'd10, v, 5'd15, 12'h3d0, ms);
		csr_step("csrrs mscratch read", 3'b010, `CSR_MSCRATCH, 5'd0, '0, 5'd16, 12'h3d4, ms);
		csr_step("csrrw mepc", 3'b001, `CSR_MEPC, 5'd13, w, 5'd17, 12'h3d8, ep);
		csr_step("csrrs mepc read", 3'b010, `CSR_MEPC, 5'd0, '0, 5'd18, 12'h3dc, ep);
		emit(`INST_EBREAK);
		run_program("load_csr");
	endtask

	// apb memory with 0 to 2 wait states
	always begin
		@(posedge clk);
		#1;
		pready = 1'b0;
		if (psel && !penable) begin
			wait_rng = xorshift(wait_rng);
			waits = int'(wait_rng % 3);
		end else if (psel && penable) begin
			if (waits > 0) begin
				waits--;
			end else begin
				pready = 1'b1;
				prdata = mem[paddr[9:2]];
				if (pwrite) begin
					for (int i = 0; i < 4; i++)
						if (pstrb[i])
							mem[paddr[9:2]][8*i +: 8] = pwdata[8*i +: 8];
				end
			end
		end
	end

	// store monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (psel && !penable)
				setup_addr = paddr;
			if (psel && penable)
				check_word("paddr held through access", setup_addr, paddr);
			if (halted) begin
				assert (!psel) else begin
					errors++;
					$display("APB transfer started after halt, paddr %h", paddr);
				end
			end
			if (psel && penable && pready && pwrite) begin
				assert (exp_addr.size() != 0) else begin
					errors++;
					$display("unexpected store to %h, data %h", paddr, pwdata);
				end
				if (exp_addr.size() != 0) begin
					mon_name = exp_name.pop_front();
					check_word({mon_name, " paddr"}, exp_addr.pop_front(), paddr);
					check_word({mon_name, " pstrb"}, {28'b0, exp_strb.pop_front()}, {28'b0, pstrb});
					check_word({mon_name, " pwdata"}, exp_data.pop_front(),
						pwdata & byte_lanes(pstrb));
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		pready = 1'b0;
		prdata = '0;
		pslverr = 1'b0;
		prog_rng = 32'd61;
		wait_rng = 32'd61;
		waits = 0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		setup_addr = '0;
		test_alu();
		if (!timed_out)
			test_branch();
		if (!timed_out)
			test_partial();
		if (!timed_out)
			test_load_csr();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
design/rv_pkg.sv
design/rv_idu.sv
design/rv_exu.sv
design/rv_regfile.sv
design/rv_csr.sv
design/rv_apb_master.sv
design/rv_core.sv
sim/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF '** PASS **' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
